// ==== src/axi_pkg.sv ====
package axi_pkg;

  // Bus widths
  parameter int AXI_ADDR_BITS = 32;
  parameter int AXI_DATA_BITS = 32;
  parameter int AXI_STRB_BITS = AXI_DATA_BITS / 8;

  // AWLEN holds beats minus one
  typedef logic [7:0] axi_len_t;

  typedef logic [1:0] axi_resp_t;

  parameter axi_resp_t RESP_OKAY   = 2'b00;
  parameter axi_resp_t RESP_DECERR = 2'b11;

  // One write transaction at a time, address through response
  typedef enum logic [1:0] {
    ST_IDLE,
    ST_ADDR,
    ST_DATA,
    ST_RESP
  } wr_state_t;

endpackage

// ==== src/addr_map_pkg.sv ====
package addr_map_pkg;

  // Top nibble picks the subordinate
  parameter int REGION_BITS = 4;
  parameter int OFFSET_BITS = 28;

  typedef struct packed {
    logic [REGION_BITS-1:0] region;
    logic [OFFSET_BITS-1:0] offset;
  } addr_fields_t;

  // Same address word, flat or split
  typedef union packed {
    logic [REGION_BITS+OFFSET_BITS-1:0] flat;
    addr_fields_t                       fields;
  } addr_word_u;

endpackage

// ==== src/wr_arbiter_fsm.sv ====
`timescale 1ns/1ps

module wr_arbiter_fsm
  import axi_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  logic      m0_awvalid,
  input  logic      m1_awvalid,
  input  logic      aw_fire,
  input  logic      w_fire,
  input  logic      last_beat,
  input  logic      b_fire,
  output wr_state_t state,
  output logic      grant
);

  wr_state_t state_next;
  logic      grant_next;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      state <= ST_IDLE;
      // Starts as if m1 won last, so m0 takes the first tie
      grant <= 1'b1;
    end else begin
      state <= state_next;
      grant <= grant_next;
    end
  end

  // Grant only moves when leaving idle
  always_comb begin
    grant_next = grant;
    if (state == ST_IDLE) begin
      unique case ({m1_awvalid, m0_awvalid})
        2'b01:   grant_next = 1'b0;
        2'b10:   grant_next = 1'b1;
        2'b11:   grant_next = ~grant;
        default: grant_next = grant;
      endcase
    end
  end

  always_comb begin
    state_next = state;
    unique case (state)
      ST_IDLE: begin
        if (m0_awvalid || m1_awvalid) begin
          state_next = ST_ADDR;
        end
      end
      ST_ADDR: begin
        if (aw_fire) begin
          state_next = ST_DATA;
        end
      end
      ST_DATA: begin
        // Beat count ends the burst, not WLAST
        if (w_fire && last_beat) begin
          state_next = ST_RESP;
        end
      end
      ST_RESP: begin
        if (b_fire) begin
          state_next = ST_IDLE;
        end
      end
      default: state_next = ST_IDLE;
    endcase
  end

endmodule

// ==== src/burst_beat_counter.sv ====
`timescale 1ns/1ps

module burst_beat_counter
  import axi_pkg::*;
(
  input  logic     clk,
  input  logic     rstn,
  input  logic     aw_fire,
  input  axi_len_t awlen,
  input  logic     w_fire,
  output logic     last_beat
);

  // Beats still to come after the current one
  axi_len_t remaining;

  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      remaining <= '0;
    end else if (aw_fire) begin
      remaining <= awlen;
    end else if (w_fire && (remaining != '0)) begin
      remaining <= remaining - 1'b1;
    end
  end

  assign last_beat = (remaining == '0);

endmodule

// ==== src/aw_router.sv ====
`timescale 1ns/1ps

module aw_router
  import axi_pkg::*;
  import addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = 4
) (
  input  logic                                     clk,
  input  logic                                     rstn,
  input  wr_state_t                                state,
  input  logic                                     grant,
  input  logic [AXI_ADDR_BITS-1:0]                 m0_awaddr,
  input  axi_len_t                                 m0_awlen,
  input  logic                                     m0_awvalid,
  output logic                                     m0_awready,
  input  logic [AXI_ADDR_BITS-1:0]                 m1_awaddr,
  input  axi_len_t                                 m1_awlen,
  input  logic                                     m1_awvalid,
  output logic                                     m1_awready,
  output logic [NUM_SLAVES-1:0][AXI_ADDR_BITS-1:0] s_awaddr,
  output axi_len_t [NUM_SLAVES-1:0]                s_awlen,
  output logic [NUM_SLAVES-1:0]                    s_awvalid,
  input  logic [NUM_SLAVES-1:0]                    s_awready,
  output logic [REGION_BITS-1:0]                   sel,
  output logic                                     unmapped,
  output logic                                     aw_fire,
  output axi_len_t                                 awlen
);

  addr_word_u aw_word;
  logic       aw_valid;
  logic       aw_ready;
  logic       hit;

  assign aw_word.flat = grant ? m1_awaddr : m0_awaddr;
  assign awlen        = grant ? m1_awlen : m0_awlen;
  assign aw_valid     = (state == ST_ADDR) && (grant ? m1_awvalid : m0_awvalid);

  // Region decode, regions past the last subordinate are absorbed here
  always_comb begin
    hit       = 1'b0;
    aw_ready  = 1'b0;
    s_awaddr  = '0;
    s_awlen   = '0;
    s_awvalid = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (aw_word.fields.region == REGION_BITS'(i)) begin
        hit          = 1'b1;
        aw_ready     = s_awready[i];
        s_awaddr[i]  = aw_word.flat;
        s_awlen[i]   = awlen;
        s_awvalid[i] = aw_valid;
      end
    end
    if (!hit) begin
      aw_ready = 1'b1;
    end
  end

  assign aw_fire    = aw_valid && aw_ready;
  assign m0_awready = (state == ST_ADDR) && !grant && aw_ready;
  assign m1_awready = (state == ST_ADDR) && grant && aw_ready;

  // Target stays locked through data and response
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      sel      <= '0;
      unmapped <= 1'b0;
    end else if (aw_fire) begin
      sel      <= aw_word.fields.region;
      unmapped <= !hit;
    end
  end

endmodule

// ==== src/w_router.sv ====
`timescale 1ns/1ps

module w_router
  import axi_pkg::*;
  import addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = 4
) (
  input  wr_state_t                                state,
  input  logic                                     grant,
  input  logic [REGION_BITS-1:0]                   sel,
  input  logic                                     unmapped,
  input  logic [AXI_DATA_BITS-1:0]                 m0_wdata,
  input  logic [AXI_STRB_BITS-1:0]                 m0_wstrb,
  input  logic                                     m0_wlast,
  input  logic                                     m0_wvalid,
  output logic                                     m0_wready,
  input  logic [AXI_DATA_BITS-1:0]                 m1_wdata,
  input  logic [AXI_STRB_BITS-1:0]                 m1_wstrb,
  input  logic                                     m1_wlast,
  input  logic                                     m1_wvalid,
  output logic                                     m1_wready,
  output logic [NUM_SLAVES-1:0][AXI_DATA_BITS-1:0] s_wdata,
  output logic [NUM_SLAVES-1:0][AXI_STRB_BITS-1:0] s_wstrb,
  output logic [NUM_SLAVES-1:0]                    s_wlast,
  output logic [NUM_SLAVES-1:0]                    s_wvalid,
  input  logic [NUM_SLAVES-1:0]                    s_wready,
  output logic                                     w_fire
);

  logic [AXI_DATA_BITS-1:0] wdata;
  logic [AXI_STRB_BITS-1:0] wstrb;
  logic                     wlast;
  logic                     wvalid;
  logic                     wready;

  // Granted manager's beat
  always_comb begin
    if (grant) begin
      wdata = m1_wdata;
      wstrb = m1_wstrb;
      wlast = m1_wlast;
    end else begin
      wdata = m0_wdata;
      wstrb = m0_wstrb;
      wlast = m0_wlast;
    end
  end

  assign wvalid = (state == ST_DATA) && (grant ? m1_wvalid : m0_wvalid);

  // Only the locked subordinate sees the beat
  always_comb begin
    s_wdata  = '0;
    s_wstrb  = '0;
    s_wlast  = '0;
    s_wvalid = '0;
    wready   = 1'b0;
    if (state == ST_DATA) begin
      if (unmapped) begin
        // Sink the burst
        wready = 1'b1;
      end else begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
          if (sel == REGION_BITS'(i)) begin
            s_wdata[i]  = wdata;
            s_wstrb[i]  = wstrb;
            s_wlast[i]  = wlast;
            s_wvalid[i] = wvalid;
            wready      = s_wready[i];
          end
        end
      end
    end
  end

  assign m0_wready = !grant && wready;
  assign m1_wready = grant && wready;
  assign w_fire    = wvalid && wready;

endmodule

// ==== src/b_router.sv ====
`timescale 1ns/1ps

module b_router
  import axi_pkg::*;
  import addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = 4
) (
  input  logic                       clk,
  input  logic                       rstn,
  input  wr_state_t                  state,
  input  logic                       grant,
  input  logic [REGION_BITS-1:0]     sel,
  input  logic                       unmapped,
  input  axi_resp_t [NUM_SLAVES-1:0] s_bresp,
  input  logic [NUM_SLAVES-1:0]      s_bvalid,
  output logic [NUM_SLAVES-1:0]      s_bready,
  input  logic                       m0_bready,
  input  logic                       m1_bready,
  output axi_resp_t                  m0_bresp,
  output logic                       m0_bvalid,
  output axi_resp_t                  m1_bresp,
  output logic                       m1_bvalid,
  output logic                       b_fire
);

  axi_resp_t bresp;
  logic      bvalid;
  logic      bready;

  assign bready = grant ? m1_bready : m0_bready;

  always_comb begin
    bresp    = RESP_OKAY;
    bvalid   = 1'b0;
    s_bready = '0;
    if (state == ST_RESP) begin
      if (unmapped) begin
        // Local DECERR held until the manager takes it
        bresp  = RESP_DECERR;
        bvalid = 1'b1;
      end else begin
        for (int i = 0; i < NUM_SLAVES; i++) begin
          if (sel == REGION_BITS'(i)) begin
            bresp       = s_bresp[i];
            bvalid      = s_bvalid[i];
            s_bready[i] = bready;
          end
        end
      end
    end
  end

  assign m0_bresp  = bresp;
  assign m1_bresp  = bresp;
  assign m0_bvalid = !grant && bvalid;
  assign m1_bvalid = grant && bvalid;
  assign b_fire    = bvalid && bready;

endmodule

// ==== src/axi_write_xbar.sv ====
`timescale 1ns/1ps

module axi_write_xbar
  import axi_pkg::*;
  import addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = 4
) (
  input  logic                                     clk,
  input  logic                                     rstn,
  // Manager 0
  input  logic [AXI_ADDR_BITS-1:0]                 m0_awaddr,
  input  axi_len_t                                 m0_awlen,
  input  logic                                     m0_awvalid,
  output logic                                     m0_awready,
  input  logic [AXI_DATA_BITS-1:0]                 m0_wdata,
  input  logic [AXI_STRB_BITS-1:0]                 m0_wstrb,
  input  logic                                     m0_wlast,
  input  logic                                     m0_wvalid,
  output logic                                     m0_wready,
  output axi_resp_t                                m0_bresp,
  output logic                                     m0_bvalid,
  input  logic                                     m0_bready,
  // Manager 1
  input  logic [AXI_ADDR_BITS-1:0]                 m1_awaddr,
  input  axi_len_t                                 m1_awlen,
  input  logic                                     m1_awvalid,
  output logic                                     m1_awready,
  input  logic [AXI_DATA_BITS-1:0]                 m1_wdata,
  input  logic [AXI_STRB_BITS-1:0]                 m1_wstrb,
  input  logic                                     m1_wlast,
  input  logic                                     m1_wvalid,
  output logic                                     m1_wready,
  output axi_resp_t                                m1_bresp,
  output logic                                     m1_bvalid,
  input  logic                                     m1_bready,
  // Subordinates, indexed by region
  output logic [NUM_SLAVES-1:0][AXI_ADDR_BITS-1:0] s_awaddr,
  output axi_len_t [NUM_SLAVES-1:0]                s_awlen,
  output logic [NUM_SLAVES-1:0]                    s_awvalid,
  input  logic [NUM_SLAVES-1:0]                    s_awready,
  output logic [NUM_SLAVES-1:0][AXI_DATA_BITS-1:0] s_wdata,
  output logic [NUM_SLAVES-1:0][AXI_STRB_BITS-1:0] s_wstrb,
  output logic [NUM_SLAVES-1:0]                    s_wlast,
  output logic [NUM_SLAVES-1:0]                    s_wvalid,
  input  logic [NUM_SLAVES-1:0]                    s_wready,
  input  axi_resp_t [NUM_SLAVES-1:0]               s_bresp,
  input  logic [NUM_SLAVES-1:0]                    s_bvalid,
  output logic [NUM_SLAVES-1:0]                    s_bready
);

  wr_state_t              state;
  logic                   grant;
  logic [REGION_BITS-1:0] sel;
  logic                   unmapped;
  logic                   aw_fire;
  logic                   w_fire;
  logic                   b_fire;
  logic                   last_beat;
  axi_len_t               awlen;

  wr_arbiter_fsm i_wr_arbiter_fsm (
    .clk        (clk),
    .rstn       (rstn),
    .m0_awvalid (m0_awvalid),
    .m1_awvalid (m1_awvalid),
    .aw_fire    (aw_fire),
    .w_fire     (w_fire),
    .last_beat  (last_beat),
    .b_fire     (b_fire),
    .state      (state),
    .grant      (grant)
  );

  burst_beat_counter i_burst_beat_counter (
    .clk       (clk),
    .rstn      (rstn),
    .aw_fire   (aw_fire),
    .awlen     (awlen),
    .w_fire    (w_fire),
    .last_beat (last_beat)
  );

  aw_router #(
    .NUM_SLAVES (NUM_SLAVES)
  ) i_aw_router (
    .clk        (clk),
    .rstn       (rstn),
    .state      (state),
    .grant      (grant),
    .m0_awaddr  (m0_awaddr),
    .m0_awlen   (m0_awlen),
    .m0_awvalid (m0_awvalid),
    .m0_awready (m0_awready),
    .m1_awaddr  (m1_awaddr),
    .m1_awlen   (m1_awlen),
    .m1_awvalid (m1_awvalid),
    .m1_awready (m1_awready),
    .s_awaddr   (s_awaddr),
    .s_awlen    (s_awlen),
    .s_awvalid  (s_awvalid),
    .s_awready  (s_awready),
    .sel        (sel),
    .unmapped   (unmapped),
    .aw_fire    (aw_fire),
    .awlen      (awlen)
  );

  w_router #(
    .NUM_SLAVES (NUM_SLAVES)
  ) i_w_router (
    .state     (state),
    .grant     (grant),
    .sel       (sel),
    .unmapped  (unmapped),
    .m0_wdata  (m0_wdata),
    .m0_wstrb  (m0_wstrb),
    .m0_wlast  (m0_wlast),
    .m0_wvalid (m0_wvalid),
    .m0_wready (m0_wready),
    .m1_wdata  (m1_wdata),
    .m1_wstrb  (m1_wstrb),
    .m1_wlast  (m1_wlast),
    .m1_wvalid (m1_wvalid),
    .m1_wready (m1_wready),
    .s_wdata   (s_wdata),
    .s_wstrb   (s_wstrb),
    .s_wlast   (s_wlast),
    .s_wvalid  (s_wvalid),
    .s_wready  (s_wready),
    .w_fire    (w_fire)
  );

  b_router #(
    .NUM_SLAVES (NUM_SLAVES)
  ) i_b_router (
    .clk       (clk),
    .rstn      (rstn),
    .state     (state),
    .grant     (grant),
    .sel       (sel),
    .unmapped  (unmapped),
    .s_bresp   (s_bresp),
    .s_bvalid  (s_bvalid),
    .s_bready  (s_bready),
    .m0_bready (m0_bready),
    .m1_bready (m1_bready),
    .m0_bresp  (m0_bresp),
    .m0_bvalid (m0_bvalid),
    .m1_bresp  (m1_bresp),
    .m1_bvalid (m1_bvalid),
    .b_fire    (b_fire)
  );

endmodule

// ==== verification/axi_write_xbar_chk.sv ====
`timescale 1ns/1ps

module axi_write_xbar_chk
  import axi_pkg::*;
  import addr_map_pkg::*;
#(
  parameter int NUM_SLAVES = 4
) (
  input logic                                     clk,
  input logic                                     rstn,
  input wr_state_t                                state,
  input logic [AXI_ADDR_BITS-1:0]                 m0_awaddr,
  input logic [AXI_ADDR_BITS-1:0]                 m1_awaddr,
  input axi_len_t                                 m0_awlen,
  input axi_len_t                                 m1_awlen,
  input logic [AXI_DATA_BITS-1:0]                 m0_wdata,
  input logic [AXI_DATA_BITS-1:0]                 m1_wdata,
  input logic [AXI_STRB_BITS-1:0]                 m0_wstrb,
  input logic [AXI_STRB_BITS-1:0]                 m1_wstrb,
  input logic                                     m0_awvalid,
  input logic                                     m0_awready,
  input logic                                     m0_wlast,
  input logic                                     m0_wvalid,
  input logic                                     m0_wready,
  input logic                                     m1_awvalid,
  input logic                                     m1_awready,
  input logic                                     m1_wlast,
  input logic                                     m1_wvalid,
  input logic                                     m1_wready,
  input axi_resp_t                                m0_bresp,
  input axi_resp_t                                m1_bresp,
  input logic                                     m0_bvalid,
  input logic                                     m0_bready,
  input logic                                     m1_bvalid,
  input logic                                     m1_bready,
  input logic [NUM_SLAVES-1:0][AXI_ADDR_BITS-1:0] s_awaddr,
  input axi_len_t [NUM_SLAVES-1:0]                s_awlen,
  input logic [NUM_SLAVES-1:0][AXI_DATA_BITS-1:0] s_wdata,
  input logic [NUM_SLAVES-1:0][AXI_STRB_BITS-1:0] s_wstrb,
  input logic [NUM_SLAVES-1:0]                    s_awvalid,
  input logic [NUM_SLAVES-1:0]                    s_awready,
  input logic [NUM_SLAVES-1:0]                    s_wlast,
  input logic [NUM_SLAVES-1:0]                    s_wvalid,
  input logic [NUM_SLAVES-1:0]                    s_wready,
  input logic [NUM_SLAVES-1:0]                    s_bready
);

  int unsigned fail_count = 0;

  addr_word_u aw_word;
  logic       aw_hs;
  logic       aw_unmapped;
  logic       s_aw_hs;
  logic       s_w_hs;
  logic       b_hs;
  logic       quiet;
  axi_len_t   s_len;
  axi_len_t   beats_left;
  logic       w_open;
  logic       owner;
  logic       contest;
  logic       dec_pend;

  assign aw_word.flat = m1_awready ? m1_awaddr : m0_awaddr;
  assign aw_hs        = (m0_awvalid && m0_awready) || (m1_awvalid && m1_awready);
  assign aw_unmapped  = aw_word.fields.region >= NUM_SLAVES;
  assign s_aw_hs      = |(s_awvalid & s_awready);
  assign s_w_hs       = |(s_wvalid & s_wready);
  assign b_hs         = (m0_bvalid && m0_bready) || (m1_bvalid && m1_bready);
  assign quiet = !(m0_awready || m1_awready || m0_wready || m1_wready ||
                   m0_bvalid || m1_bvalid) &&
                 (s_awvalid == '0) && (s_wvalid == '0) && (s_bready == '0);

  always_comb begin
    s_len = '0;
    for (int i = 0; i < NUM_SLAVES; i++) begin
      if (s_awvalid[i]) begin
        s_len = s_awlen[i];
      end
    end
  end

  // Owner is also the last winner and m0 wins the first tie
  always_ff @(posedge clk, negedge rstn) begin
    if (!rstn) begin
      owner      <= 1'b1;
      contest    <= 1'b0;
      dec_pend   <= 1'b0;
      w_open     <= 1'b0;
      beats_left <= '0;
    end else begin
      if (state == ST_IDLE) begin
        contest <= m0_awvalid && m1_awvalid;
      end
      if (aw_hs) begin
        owner <= m1_awready;
      end
      if (aw_hs && aw_unmapped) begin
        dec_pend <= 1'b1;
      end else if (b_hs) begin
        dec_pend <= 1'b0;
      end
      if (s_aw_hs) begin
        w_open     <= 1'b1;
        beats_left <= s_len;
      end else if (s_w_hs) begin
        if (beats_left == '0) begin
          w_open <= 1'b0;
        end else begin
          beats_left <= beats_left - 1'b1;
        end
      end
    end
  end

  for (genvar i = 0; i < NUM_SLAVES; i++) begin : g_sub
    addr_word_u s_word;

    assign s_word.flat = s_awaddr[i];

    a_aw_region: assert property (@(posedge clk) disable iff (!rstn)
      s_awvalid[i] |-> s_word.fields.region == REGION_BITS'(i))
      else begin
        fail_count++;
        $error("AW valid on subordinate %0d carries a different region", i);
      end

    a_aw_addr: assert property (@(posedge clk) disable iff (!rstn)
      s_awvalid[i] && s_awready[i] |->
        s_awaddr[i] == aw_word.flat &&
        s_awlen[i] == (m1_awready ? m1_awlen : m0_awlen))
      else begin
        fail_count++;
        $error("Subordinate %0d address or length differs from the accepted request", i);
      end

    a_w_steer: assert property (@(posedge clk) disable iff (!rstn)
      s_wvalid[i] |->
        (owner ? m1_wvalid : m0_wvalid) &&
        s_wdata[i] == (owner ? m1_wdata : m0_wdata) &&
        s_wstrb[i] == (owner ? m1_wstrb : m0_wstrb) &&
        s_wlast[i] == (owner ? m1_wlast : m0_wlast) &&
        s_wready[i] == (owner ? m1_wready : m0_wready))
      else begin
        fail_count++;
        $error("W beat on subordinate %0d does not match the owning manager", i);
      end
  end

  a_aw_onehot: assert property (@(posedge clk) disable iff (!rstn)
    $onehot0(s_awvalid))
    else begin
      fail_count++;
      $error("More than one subordinate sees AW valid");
    end

  // Beat count from the subordinate's AWLEN
  a_w_last: assert property (@(posedge clk) disable iff (!rstn)
    s_w_hs && beats_left == '0 |-> |(s_wvalid & s_wlast))
    else begin
      fail_count++;
      $error("Final beat of a burst was accepted without WLAST");
    end

  a_w_extra: assert property (@(posedge clk) disable iff (!rstn)
    !w_open |-> s_wvalid == '0)
    else begin
      fail_count++;
      $error("W valid reached a subordinate outside an open burst");
    end

  a_unmapped_aw: assert property (@(posedge clk) disable iff (!rstn)
    aw_hs && aw_unmapped |-> s_awvalid == '0)
    else begin
      fail_count++;
      $error("Unmapped address was forwarded to a subordinate");
    end

  a_unmapped_w: assert property (@(posedge clk) disable iff (!rstn)
    dec_pend |-> s_wvalid == '0)
    else begin
      fail_count++;
      $error("W beat of an unmapped burst was forwarded to a subordinate");
    end

  a_decerr: assert property (@(posedge clk) disable iff (!rstn)
    dec_pend && (m0_bvalid || m1_bvalid) |->
      (owner ? (m1_bvalid && m1_bresp == RESP_DECERR)
             : (m0_bvalid && m0_bresp == RESP_DECERR)))
    else begin
      fail_count++;
      $error("Unmapped burst did not end with DECERR to its owner");
    end

  a_b_single: assert property (@(posedge clk) disable iff (!rstn)
    !(m0_bvalid && m1_bvalid))
    else begin
      fail_count++;
      $error("B valid reached both managers at once");
    end

  a_round_robin: assert property (@(posedge clk) disable iff (!rstn)
    aw_hs && contest |-> m1_awready != owner)
    else begin
      fail_count++;
      $error("Contended grant went to the same manager twice");
    end

  a_reset: assert property (@(posedge clk)
    (!rstn || !$past(rstn)) |-> quiet)
    else begin
      fail_count++;
      $error("Valid or ready output high during or right after reset");
    end

endmodule

bind axi_write_xbar axi_write_xbar_chk #(
  .NUM_SLAVES (NUM_SLAVES)
) i_axi_write_xbar_chk (.*);

// ==== verification/axi_write_xbar_tb.sv ====
`timescale 1ns/1ps

module axi_write_xbar_tb
  import axi_pkg::*;
  import addr_map_pkg::*;
;

  localparam int NUM_SLAVES = 4;
  localparam int BURSTS     = 20;
  // Two managers times 8 beats plus 4 overhead, times 4 for stalls
  localparam int TIMEOUT_CYCLES = 2 * BURSTS * (8 + 4) * 4;

  logic                     clk;
  logic                     rstn;
  logic [AXI_ADDR_BITS-1:0] awaddr [2];
  axi_len_t                 awlen [2];
  logic [AXI_DATA_BITS-1:0] wdata [2];
  logic [AXI_STRB_BITS-1:0] wstrb [2];
  logic [1:0]               awvalid;
  logic [1:0]               wvalid;
  logic [1:0]               wlast;
  logic [1:0]               bready;
  wire  [1:0]               awready;
  wire  [1:0]               wready;
  wire  [1:0]               bvalid;
  axi_resp_t                m0_bresp;
  axi_resp_t                m1_bresp;

  logic [NUM_SLAVES-1:0][AXI_ADDR_BITS-1:0] s_awaddr;
  axi_len_t [NUM_SLAVES-1:0]                s_awlen;
  logic [NUM_SLAVES-1:0]                    s_awvalid;
  logic [NUM_SLAVES-1:0]                    s_awready;
  logic [NUM_SLAVES-1:0][AXI_DATA_BITS-1:0] s_wdata;
  logic [NUM_SLAVES-1:0][AXI_STRB_BITS-1:0] s_wstrb;
  logic [NUM_SLAVES-1:0]                    s_wlast;
  logic [NUM_SLAVES-1:0]                    s_wvalid;
  logic [NUM_SLAVES-1:0]                    s_wready;
  axi_resp_t [NUM_SLAVES-1:0]               s_bresp;
  logic [NUM_SLAVES-1:0]                    s_bvalid;
  logic [NUM_SLAVES-1:0]                    s_bready;

  logic [31:0] rng = 32'hd4ac_4b6d;
  int          errors = 0;
  int          cycles = 0;
  int          b_count [2];
  int          dec_seen [2];
  int          dec_issued [2];

  axi_write_xbar #(
    .NUM_SLAVES (NUM_SLAVES)
  ) i_axi_write_xbar (
    .clk        (clk),
    .rstn       (rstn),
    .m0_awaddr  (awaddr[0]),
    .m0_awlen   (awlen[0]),
    .m0_awvalid (awvalid[0]),
    .m0_awready (awready[0]),
    .m0_wdata   (wdata[0]),
    .m0_wstrb   (wstrb[0]),
    .m0_wlast   (wlast[0]),
    .m0_wvalid  (wvalid[0]),
    .m0_wready  (wready[0]),
    .m0_bresp   (m0_bresp),
    .m0_bvalid  (bvalid[0]),
    .m0_bready  (bready[0]),
    .m1_awaddr  (awaddr[1]),
    .m1_awlen   (awlen[1]),
    .m1_awvalid (awvalid[1]),
    .m1_awready (awready[1]),
    .m1_wdata   (wdata[1]),
    .m1_wstrb   (wstrb[1]),
    .m1_wlast   (wlast[1]),
    .m1_wvalid  (wvalid[1]),
    .m1_wready  (wready[1]),
    .m1_bresp   (m1_bresp),
    .m1_bvalid  (bvalid[1]),
    .m1_bready  (bready[1]),
    .s_awaddr   (s_awaddr),
    .s_awlen    (s_awlen),
    .s_awvalid  (s_awvalid),
    .s_awready  (s_awready),
    .s_wdata    (s_wdata),
    .s_wstrb    (s_wstrb),
    .s_wlast    (s_wlast),
    .s_wvalid   (s_wvalid),
    .s_wready   (s_wready),
    .s_bresp    (s_bresp),
    .s_bvalid   (s_bvalid),
    .s_bready   (s_bready)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] xorshift32();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  task automatic check_count(input string name, input int got, input int expected);
    if (got != expected) begin
      $display("Fail %s: got %h expected %h", name, got, expected);
      errors++;
    end
  endtask

  // One manager runs its bursts, each with address, beats and response
  task automatic run_manager(input int m);
    logic [31:0] r;
    addr_word_u  word;
    axi_len_t    len;
    for (int n = 0; n < BURSTS; n++) begin
      r = xorshift32();
      // No gap half the time, so both managers contend
      repeat (r[0] ? 0 : int'(r[2:1])) begin
        @(posedge clk);
        #1;
      end
      word.flat = xorshift32();
      if (r[3]) begin
        word.fields.region = REGION_BITS'(r[5:4]);
      end
      len = axi_len_t'(r[8:6]);
      if (word.fields.region >= NUM_SLAVES) begin
        dec_issued[m]++;
      end
      awaddr[m]  = word.flat;
      awlen[m]   = len;
      awvalid[m] = 1'b1;
      @(posedge clk);
      while (!awready[m]) @(posedge clk);
      #1;
      awvalid[m] = 1'b0;
      for (int b = 0; b <= int'(len); b++) begin
        r         = xorshift32();
        wdata[m]  = xorshift32();
        wstrb[m]  = AXI_STRB_BITS'(r);
        wlast[m]  = (b == int'(len));
        wvalid[m] = 1'b1;
        @(posedge clk);
        while (!wready[m]) @(posedge clk);
        #1;
      end
      wvalid[m] = 1'b0;
      wlast[m]  = 1'b0;
      @(posedge clk);
      while (!bvalid[m]) @(posedge clk);
      #1;
    end
  endtask

  // Subordinates stall ready at random and answer OKAY one cycle after WLAST
  always @(posedge clk) begin : subordinates
    logic [NUM_SLAVES-1:0] w_done;
    logic [NUM_SLAVES-1:0] b_done;
    logic [31:0]           r;
    w_done = s_wvalid & s_wready & s_wlast;
    b_done = s_bvalid & s_bready;
    r      = xorshift32();
    #1;
    s_awready = NUM_SLAVES'(r[15:0] | r[31:16]);
    s_wready  = NUM_SLAVES'((r[15:0] | r[31:16]) >> 8);
    s_bvalid  = (s_bvalid & ~b_done) | w_done;
  end

  // Count every B handshake and the DECERR among them
  always @(posedge clk) begin
    for (int m = 0; m < 2; m++) begin
      if (rstn && bvalid[m] && bready[m]) begin
        b_count[m]++;
        if (((m == 0) ? m0_bresp : m1_bresp) == RESP_DECERR) begin
          dec_seen[m]++;
        end
      end
    end
  end

  always @(posedge clk) begin
    cycles++;
    if (cycles == TIMEOUT_CYCLES) begin
      $display("Timeout: bursts still open after %0d cycles", TIMEOUT_CYCLES);
      $display("TEST FAIL");
      $finish;
    end
  end

  initial begin
    clk       = 1'b0;
    rstn      = 1'b0;
    awvalid   = '0;
    wvalid    = '0;
    wlast     = '0;
    bready    = '0;
    s_awready = '0;
    s_wready  = '0;
    s_bvalid  = '0;
    s_bresp   = {NUM_SLAVES{RESP_OKAY}};
    for (int m = 0; m < 2; m++) begin
      awaddr[m]     = '0;
      awlen[m]      = '0;
      wdata[m]      = '0;
      wstrb[m]      = '0;
      b_count[m]    = 0;
      dec_seen[m]   = 0;
      dec_issued[m] = 0;
    end
    repeat (3) @(posedge clk);
    #1;
    rstn = 1'b1;
    // Managers take any B at once, so a stray response is counted
    bready = '1;
    fork
      run_manager(0);
      run_manager(1);
    join
    repeat (4) @(posedge clk);
    check_count("m0 b_count", b_count[0], BURSTS);
    check_count("m1 b_count", b_count[1], BURSTS);
    check_count("m0 decerr_count", dec_seen[0], dec_issued[0]);
    check_count("m1 decerr_count", dec_seen[1], dec_issued[1]);
    $display("Errors: %0d count checks, %0d assertions", errors,
             i_axi_write_xbar.i_axi_write_xbar_chk.fail_count);
    if (errors == 0 && i_axi_write_xbar.i_axi_write_xbar_chk.fail_count == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule

// ==== axi_write_xbar.f ====
src/axi_pkg.sv
src/addr_map_pkg.sv
src/wr_arbiter_fsm.sv
src/burst_beat_counter.sv
src/aw_router.sv
src/w_router.sv
src/b_router.sv
src/axi_write_xbar.sv
verification/axi_write_xbar_chk.sv
verification/axi_write_xbar_tb.sv

// ==== Bender.yml ====
package:
  name: axi_write_xbar

sources:
  # Packages first, then the blocks, then the top level
  - src/axi_pkg.sv
  - src/addr_map_pkg.sv
  - src/wr_arbiter_fsm.sv
  - src/burst_beat_counter.sv
  - src/aw_router.sv
  - src/w_router.sv
  - src/b_router.sv
  - src/axi_write_xbar.sv

  - target: test
    files:
      - verification/axi_write_xbar_chk.sv
      - verification/axi_write_xbar_tb.sv
